// File: rtl/mem_pkg.sv
package mem_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// Data, address and pc share one width
	localparam int word_w = 16;

	// Request id carried next to the pc
	localparam int act_w = 16;

	////////////////////////////////////////////////////////////
	// Memory map
	////////////////////////////////////////////////////////////

	// UART status word, answered without touching a bank
	localparam logic [word_w-1:0] status_addr = 16'hBF01;

	// Upper bits of the status word
	// Bit 1 is the receive flag, bit 0 the always free transmitter
	localparam logic [word_w-3:0] status_fill = '1;

	////////////////////////////////////////////////////////////
	// Controller FSM
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ctl_idle,
		ctl_wait,
		ctl_reply
	} ctl_state_t;

endpackage

// File: rtl/bank_if.sv
`timescale 1ns/1ps

interface bank_if
	import mem_pkg::*;
();

	// Request side, held by the controller
	logic need_to_work;
	logic write;
	logic [word_w-1:0] addr;
	logic [word_w-1:0] wdata;

	// One cycle completion pulse, read data valid with it
	logic work_done;
	logic [word_w-1:0] feedback;

	modport ctl (
		output need_to_work,
		output write,
		output addr,
		output wdata,
		input work_done,
		input feedback
	);

	modport bank (
		input need_to_work,
		input write,
		input addr,
		input wdata,
		output work_done,
		output feedback
	);

endinterface

// File: rtl/uart_status.sv
`timescale 1ns/1ps

module uart_status (
	input logic ram1_work_done,
	input logic reset,
	input logic uart_rx_strobe,
	input logic uart_reading,
	output logic data_ready
);

	// Receive flag as seen in the status word
	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			data_ready <= 1'b0;
		end else if (uart_rx_strobe) begin
			// A new byte beats a read in the same cycle
			data_ready <= 1'b1;
		end else if (uart_reading) begin
			data_ready <= 1'b0;
		end
	end

endmodule

// File: rtl/sram_bank.sv
`timescale 1ns/1ps

module sram_bank
	import mem_pkg::*;
#(
	parameter int bank_addr_bits = 8,
	// Two or more cycles
	parameter int latency = 3
) (
	input logic ram1_work_done,
	input logic reset,
	bank_if.bank port
);

	localparam int depth = 1 << bank_addr_bits;
	localparam int cnt_w = $clog2(latency + 1);

	logic [word_w-1:0] mem [depth];

	logic busy;
	logic [cnt_w-1:0] cnt;
	logic start;
	logic finish;

	// Command captured at start
	logic lat_write;
	logic [bank_addr_bits-1:0] lat_addr;
	logic [word_w-1:0] lat_wdata;

	// The pulse cycle still counts as busy
	assign start = !busy && !port.work_done && port.need_to_work;
	assign finish = busy && (cnt <= cnt_w'(1));

	////////////////////////////////////////////////////////////
	// Countdown
	////////////////////////////////////////////////////////////

	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			busy <= 1'b0;
			cnt <= '0;
			port.work_done <= 1'b0;
		end else begin
			port.work_done <= finish;
			if (start) begin
				busy <= 1'b1;
				cnt <= cnt_w'(latency - 1);
			end else if (finish) begin
				busy <= 1'b0;
			end else if (busy) begin
				cnt <= cnt - cnt_w'(1);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Array access
	////////////////////////////////////////////////////////////

	always_ff @(posedge ram1_work_done) begin
		if (start) begin
			lat_write <= port.write;
			lat_addr <= port.addr[bank_addr_bits-1:0];
			lat_wdata <= port.wdata;
		end
		if (finish) begin
			if (lat_write) begin
				mem[lat_addr] <= lat_wdata;
			end
			// Old contents on a write, nobody looks at it
			port.feedback <= mem[lat_addr];
		end
	end

	assert property (@(posedge ram1_work_done) disable iff (reset)
		port.work_done |-> $past(start, latency));

endmodule

// File: rtl/ram_controller.sv
`timescale 1ns/1ps

module ram_controller
	import mem_pkg::*;
(
	input logic ram1_work_done,
	input logic reset,
	input logic mem_rd,
	input logic mem_wr,
	input logic [word_w-1:0] addr,
	input logic [word_w-1:0] wdata,
	input logic [word_w-1:0] pc,
	input logic [act_w-1:0] act,
	input logic uart_data_ready,
	bank_if.ctl ram1,
	bank_if.ctl ram2,
	output logic work_done,
	output logic [word_w-1:0] feedback,
	output logic [word_w-1:0] done_pc_out,
	output logic [word_w-1:0] done_act1_out,
	output logic [word_w-1:0] done_act2_out
);

	ctl_state_t state;
	logic ram1_need;
	logic ram2_need;
	logic sel_ram1;
	logic [word_w-1:0] tag_pc;
	logic [act_w-1:0] tag_act;
	logic [word_w-1:0] done_pc1;
	logic [word_w-1:0] done_pc2;
	logic [act_w-1:0] done_act1;
	logic [act_w-1:0] done_act2;

	logic req;
	logic hit_status;
	logic hit_ram1;
	logic same_bank;
	logic tag_match;
	logic bank_done;
	logic [word_w-1:0] bank_feedback;
	logic [word_w-1:0] status_word;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	assign req = mem_rd || mem_wr;
	assign hit_status = (addr == status_addr);
	// Upper half of the map belongs to RAM1
	assign hit_ram1 = addr[word_w-1];
	assign same_bank = !hit_status && (hit_ram1 == sel_ram1);
	assign tag_match = (pc == tag_pc) && (act == tag_act);
	assign status_word = {status_fill, uart_data_ready, 1'b1};

	assign bank_done = sel_ram1 ? ram1.work_done : ram2.work_done;
	assign bank_feedback = sel_ram1 ? ram1.feedback : ram2.feedback;

	// Both banks see the live CPU command, only need_to_work differs
	assign ram1.need_to_work = ram1_need;
	assign ram1.write = mem_wr;
	assign ram1.addr = addr;
	assign ram1.wdata = wdata;
	assign ram2.need_to_work = ram2_need;
	assign ram2.write = mem_wr;
	assign ram2.addr = addr;
	assign ram2.wdata = wdata;

	////////////////////////////////////////////////////////////
	// Request FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			state <= ctl_idle;
			ram1_need <= 1'b0;
			ram2_need <= 1'b0;
			sel_ram1 <= 1'b0;
			work_done <= 1'b0;
		end else begin
			case (state)
				ctl_idle: begin
					if (req && hit_status) begin
						feedback <= status_word;
						state <= ctl_reply;
					end else if (req) begin
						ram1_need <= hit_ram1;
						ram2_need <= !hit_ram1;
						sel_ram1 <= hit_ram1;
						tag_pc <= pc;
						tag_act <= act;
						state <= ctl_wait;
					end
				end
				ctl_wait: begin
					if (bank_done && tag_match) begin
						feedback <= bank_feedback;
						work_done <= 1'b1;
						ram1_need <= 1'b0;
						ram2_need <= 1'b0;
						state <= ctl_reply;
					end else if (bank_done && same_bank) begin
						// Stale result so the bank runs again under the new tag
						tag_pc <= pc;
						tag_act <= act;
					end else if (bank_done) begin
						// New request moved elsewhere
						ram1_need <= 1'b0;
						ram2_need <= 1'b0;
						state <= ctl_idle;
					end
				end
				ctl_reply: begin
					// Status path arrives with the pulse still low
					if (work_done) begin
						work_done <= 1'b0;
						state <= ctl_idle;
					end else begin
						work_done <= 1'b1;
					end
				end
				default: state <= ctl_idle;
			endcase
		end
	end

	// Last completed tag per bank, for debug
	always_ff @(posedge ram1_work_done) begin
		if (reset) begin
			done_pc1 <= '0;
			done_act1 <= '0;
			done_pc2 <= '0;
			done_act2 <= '0;
		end else begin
			if (ram1.work_done) begin
				done_pc1 <= tag_pc;
				done_act1 <= tag_act;
			end
			if (ram2.work_done) begin
				done_pc2 <= tag_pc;
				done_act2 <= tag_act;
			end
		end
	end

	assign done_pc_out = {done_pc1[word_w/2-1:0], done_pc2[word_w/2-1:0]};
	assign done_act1_out = done_act1;
	assign done_act2_out = done_act2;

	assert property (@(posedge ram1_work_done) disable iff (reset)
		!(ram1.need_to_work && ram2.need_to_work));

	assert property (@(posedge ram1_work_done) disable iff (reset)
		work_done |=> !work_done);

endmodule

// File: rtl/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top
	import mem_pkg::*;
#(
	parameter int bank_addr_bits = 8,
	parameter int ram1_latency = 3,
	parameter int ram2_latency = 5
) (
	input logic ram1_work_done,
	input logic reset,
	input logic mem_rd,
	input logic mem_wr,
	input logic [word_w-1:0] addr,
	input logic [word_w-1:0] wdata,
	input logic [word_w-1:0] pc,
	input logic [act_w-1:0] act,
	input logic uart_rx_strobe,
	input logic uart_reading,
	output logic work_done,
	output logic [word_w-1:0] feedback,
	output logic [word_w-1:0] done_pc_out,
	output logic [word_w-1:0] done_act1_out,
	output logic [word_w-1:0] done_act2_out
);

	logic uart_data_ready;

	bank_if ram1_bus ();
	bank_if ram2_bus ();

	uart_status uart_i (
		.ram1_work_done(ram1_work_done),
		.reset(reset),
		.uart_rx_strobe(uart_rx_strobe),
		.uart_reading(uart_reading),
		.data_ready(uart_data_ready)
	);

	ram_controller ctl_i (
		.ram1_work_done(ram1_work_done),
		.reset(reset),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.addr(addr),
		.wdata(wdata),
		.pc(pc),
		.act(act),
		.uart_data_ready(uart_data_ready),
		.ram1(ram1_bus.ctl),
		.ram2(ram2_bus.ctl),
		.work_done(work_done),
		.feedback(feedback),
		.done_pc_out(done_pc_out),
		.done_act1_out(done_act1_out),
		.done_act2_out(done_act2_out)
	);

	// Upper half of the address map
	sram_bank #(
		.bank_addr_bits(bank_addr_bits),
		.latency(ram1_latency)
	) ram1_i (
		.ram1_work_done(ram1_work_done),
		.reset(reset),
		.port(ram1_bus.bank)
	);

	sram_bank #(
		.bank_addr_bits(bank_addr_bits),
		.latency(ram2_latency)
	) ram2_i (
		.ram1_work_done(ram1_work_done),
		.reset(reset),
		.port(ram2_bus.bank)
	);

endmodule

// File: tests/mem_checker.sv
`timescale 1ns/1ps

module mem_checker
	import mem_pkg::*;
(
	input logic ram1_work_done,
	input logic reset,
	input logic mem_rd,
	input logic mem_wr,
	input logic work_done,
	input logic [word_w-1:0] feedback,
	input logic [word_w-1:0] done_pc_out,
	input logic [word_w-1:0] done_act1_out,
	input logic [word_w-1:0] done_act2_out,
	input logic exp_is_read,
	input logic [word_w-1:0] exp_data,
	input int exp_cycles,
	input logic [word_w-1:0] exp_pc_out,
	input logic [word_w-1:0] exp_act1,
	input logic [word_w-1:0] exp_act2,
	output int test_count,
	output int error_count
);

	int cycles;
	int test_errors;
	logic reset_q;

	task automatic compare(input string name, input logic [word_w-1:0] got,
		input logic [word_w-1:0] want);
		if (got !== want) begin
			$display("Fail %s: got %h, expected %h", name, got, want);
			test_errors++;
		end
	endtask

	task automatic close_test(input string what);
		test_count++;
		error_count += test_errors;
		if (test_errors == 0) begin
			$display("test %0d %s ok", test_count, what);
		end else begin
			$display("test %0d %s failed with %0d mismatches", test_count, what, test_errors);
		end
		test_errors = 0;
	endtask

	////////////////////////////////////////////////////////////
	// Sampled on the rising edge, inputs change on the falling one
	////////////////////////////////////////////////////////////

	always @(posedge ram1_work_done) begin
		if (reset) begin
			cycles = 0;
			test_count = 0;
			error_count = 0;
			test_errors = 0;
		end else if (reset_q) begin
			// First edge out of reset
			compare("work_done", {{(word_w-1){1'b0}}, work_done}, '0);
			compare("done_pc_out", done_pc_out, '0);
			compare("done_act1_out", done_act1_out, '0);
			compare("done_act2_out", done_act2_out, '0);
			close_test("after reset");
		end else if (work_done) begin
			if (exp_cycles != 0 && cycles != exp_cycles) begin
				$display("work_done came %0d cycles after the request instead of %0d",
					cycles, exp_cycles);
				test_errors++;
			end
			if (exp_is_read) begin
				compare("feedback", feedback, exp_data);
			end
			compare("done_pc_out", done_pc_out, exp_pc_out);
			compare("done_act1_out", done_act1_out, exp_act1);
			compare("done_act2_out", done_act2_out, exp_act2);
			if (exp_is_read) begin
				close_test("read");
			end else begin
				close_test("write");
			end
			cycles = 0;
		end else if (mem_rd || mem_wr) begin
			cycles++;
		end
		reset_q = reset;
	end

endmodule

// File: tests/mem_tb.sv
`timescale 1ns/1ps

module mem_tb
	import mem_pkg::*;
();

	localparam int clk_period = 4;
	localparam int bank_addr_bits = 8;
	localparam int ram1_latency = 3;
	localparam int ram2_latency = 5;
	localparam logic [15:0] seed = 16'd40419;
	localparam logic [15:0] uart_addr = 16'hBF01;
	localparam int n_writes = 16;
	localparam int n_reads = 16;
	localparam int n_status = 3;
	localparam int n_retag = 4;
	localparam int n_ops = n_writes + n_reads + n_status + n_retag;
	// One result per operation plus the reset check
	localparam int n_tests = n_ops + 1;
	localparam int max_latency = (ram1_latency > ram2_latency) ? ram1_latency : ram2_latency;
	localparam int watchdog_cycles = n_ops * (max_latency + 10) + 50;

	logic ram1_work_done;
	logic reset;
	logic mem_rd;
	logic mem_wr;
	logic [word_w-1:0] addr;
	logic [word_w-1:0] wdata;
	logic [word_w-1:0] pc;
	logic [act_w-1:0] act;
	logic uart_rx_strobe;
	logic uart_reading;
	logic work_done;
	logic [word_w-1:0] feedback;
	logic [word_w-1:0] done_pc_out;
	logic [word_w-1:0] done_act1_out;
	logic [word_w-1:0] done_act2_out;

	// Expected response of the operation in flight
	logic exp_is_read;
	logic [word_w-1:0] exp_data;
	int exp_cycles;
	logic [word_w-1:0] exp_pc_out;
	logic [word_w-1:0] exp_act1;
	logic [word_w-1:0] exp_act2;
	int test_count;
	int error_count;

	// Reference model state
	logic [15:0] lfsr;
	logic [word_w-1:0] shadow1 [1 << bank_addr_bits];
	logic [word_w-1:0] shadow2 [1 << bank_addr_bits];
	logic [15:0] written1 [$];
	logic [15:0] written2 [$];
	logic uart_flag;
	logic [word_w-1:0] last_pc1;
	logic [word_w-1:0] last_pc2;
	logic [word_w-1:0] last_act1;
	logic [word_w-1:0] last_act2;
	logic [act_w-1:0] act_id;

	mem_subsystem_top #(
		.bank_addr_bits(bank_addr_bits),
		.ram1_latency(ram1_latency),
		.ram2_latency(ram2_latency)
	) dut_i (
		.ram1_work_done(ram1_work_done),
		.reset(reset),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.addr(addr),
		.wdata(wdata),
		.pc(pc),
		.act(act),
		.uart_rx_strobe(uart_rx_strobe),
		.uart_reading(uart_reading),
		.work_done(work_done),
		.feedback(feedback),
		.done_pc_out(done_pc_out),
		.done_act1_out(done_act1_out),
		.done_act2_out(done_act2_out)
	);

	mem_checker chk_i (
		.ram1_work_done(ram1_work_done),
		.reset(reset),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.work_done(work_done),
		.feedback(feedback),
		.done_pc_out(done_pc_out),
		.done_act1_out(done_act1_out),
		.done_act2_out(done_act2_out),
		.exp_is_read(exp_is_read),
		.exp_data(exp_data),
		.exp_cycles(exp_cycles),
		.exp_pc_out(exp_pc_out),
		.exp_act1(exp_act1),
		.exp_act2(exp_act2),
		.test_count(test_count),
		.error_count(error_count)
	);

	initial begin
		ram1_work_done = 1'b0;
		forever #(clk_period / 2) ram1_work_done = ~ram1_work_done;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Status word has every bit set except bit 1, the receive flag
	function automatic logic [word_w-1:0] expect_read(input logic [15:0] a);
		if (a == uart_addr) begin
			return {14'h3fff, uart_flag, 1'b1};
		end else if (a[15]) begin
			return shadow1[a[bank_addr_bits-1:0]];
		end
		return shadow2[a[bank_addr_bits-1:0]];
	endfunction

	// Issue cycle, bank latency, feedback register
	function automatic int expect_cycles(input logic [15:0] a);
		if (a == uart_addr) begin
			return 2;
		end else if (a[15]) begin
			return ram1_latency + 2;
		end
		return ram2_latency + 2;
	endfunction

	task automatic take_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[14:0], lfsr[0]};
		end
	endtask

	task automatic fresh_addr(input logic upper, output logic [15:0] a);
		logic [15:0] r;
		take_bits(15, r);
		a = {upper, r[14:0]};
		// Keep clear of the status word
		if (a == uart_addr) begin
			a = a ^ 16'h0002;
		end
	endtask

	task automatic pick_written(input logic upper, output logic [15:0] a);
		logic [15:0] r;
		int idx;
		take_bits(8, r);
		if (upper) begin
			idx = int'(r) % written1.size();
			a = written1[idx];
		end else begin
			idx = int'(r) % written2.size();
			a = written2[idx];
		end
	endtask

	// Debug tags follow the last completion of each bank
	task automatic note_tags(input logic [15:0] a, input logic [15:0] p, input logic [15:0] t);
		if (a != uart_addr) begin
			if (a[15]) begin
				last_pc1 = p;
				last_act1 = t;
			end else begin
				last_pc2 = p;
				last_act2 = t;
			end
		end
		exp_pc_out = {last_pc1[7:0], last_pc2[7:0]};
		exp_act1 = last_act1;
		exp_act2 = last_act2;
	endtask

	////////////////////////////////////////////////////////////
	// CPU side
	////////////////////////////////////////////////////////////

	task automatic wait_done();
		do begin
			@(negedge ram1_work_done);
		end while (!work_done);
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		// Idle cycle between operations
		@(negedge ram1_work_done);
	endtask

	task automatic access(input logic is_write, input logic [15:0] a, input logic [15:0] d);
		logic [15:0] p;
		take_bits(16, p);
		act_id = act_id + 16'd1;
		exp_is_read = !is_write;
		exp_data = expect_read(a);
		exp_cycles = expect_cycles(a);
		note_tags(a, p, act_id);
		if (is_write && a[15]) begin
			shadow1[a[bank_addr_bits-1:0]] = d;
		end else if (is_write) begin
			shadow2[a[bank_addr_bits-1:0]] = d;
		end
		mem_rd = !is_write;
		mem_wr = is_write;
		addr = a;
		wdata = d;
		pc = p;
		act = act_id;
		wait_done();
	endtask

	// Read whose pc, act and address move on while the bank is busy
	task automatic access_retag(input logic [15:0] a, input logic [15:0] a_new);
		logic [15:0] p;
		take_bits(16, p);
		act_id = act_id + 16'd1;
		exp_is_read = 1'b1;
		exp_cycles = 0;
		mem_rd = 1'b1;
		mem_wr = 1'b0;
		addr = a;
		wdata = '0;
		pc = p;
		act = act_id;
		repeat (2) @(negedge ram1_work_done);
		act_id = act_id + 16'd1;
		exp_data = expect_read(a_new);
		note_tags(a_new, p + 16'd2, act_id);
		addr = a_new;
		pc = p + 16'd2;
		act = act_id;
		wait_done();
	endtask

	initial begin : stimulus
		logic [15:0] a;
		logic [15:0] a2;
		logic [15:0] d;
		logic [15:0] r;

		reset = 1'b1;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		addr = '0;
		wdata = '0;
		pc = '0;
		act = '0;
		uart_rx_strobe = 1'b0;
		uart_reading = 1'b0;
		lfsr = seed;
		uart_flag = 1'b0;
		last_pc1 = '0;
		last_pc2 = '0;
		last_act1 = '0;
		last_act2 = '0;
		act_id = '0;
		exp_is_read = 1'b0;
		exp_data = '0;
		exp_cycles = 0;
		exp_pc_out = '0;
		exp_act1 = '0;
		exp_act2 = '0;

		repeat (3) @(negedge ram1_work_done);
		reset = 1'b0;
		repeat (2) @(negedge ram1_work_done);

		// Writes alternate between the two halves
		for (int i = 0; i < n_writes; i++) begin
			fresh_addr(i[0], a);
			take_bits(16, d);
			access(1'b1, a, d);
			if (a[15]) begin
				written1.push_back(a);
			end else begin
				written2.push_back(a);
			end
		end

		for (int i = 0; i < n_reads; i++) begin
			take_bits(1, r);
			pick_written(r[0], a);
			// Bits between the bank select and the bank index play no part
			take_bits(15 - bank_addr_bits, r);
			a2 = a;
			a2[14:bank_addr_bits] = r[14-bank_addr_bits:0];
			if (a2 != uart_addr) begin
				a = a2;
			end
			access(1'b0, a, '0);
		end

		// Status word before a byte, with one, and after it is read
		access(1'b0, uart_addr, '0);
		uart_rx_strobe = 1'b1;
		@(negedge ram1_work_done);
		uart_rx_strobe = 1'b0;
		uart_flag = 1'b1;
		access(1'b0, uart_addr, '0);
		uart_reading = 1'b1;
		@(negedge ram1_work_done);
		uart_reading = 1'b0;
		uart_flag = 1'b0;
		access(1'b0, uart_addr, '0);

		for (int i = 0; i < n_retag; i++) begin
			pick_written(i[0], a);
			pick_written(i[0], a2);
			access_retag(a, a2);
		end

		repeat (2) @(negedge ram1_work_done);
		if (test_count != n_tests) begin
			$display("Checker saw %0d results where %0d were expected", test_count, n_tests);
		end
		$display("%0d tests checked, %0d errors", test_count, error_count);
		if (error_count == 0 && test_count == n_tests) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge ram1_work_done);
		$display("Timeout, the run did not finish within %0d cycles", watchdog_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: src.f
rtl/mem_pkg.sv
rtl/bank_if.sv
rtl/uart_status.sv
rtl/sram_bank.sv
rtl/ram_controller.sv
rtl/mem_subsystem_top.sv
tests/mem_checker.sv
tests/mem_tb.sv

// File: Makefile
TOOL = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP = mem_tb
FILELIST = src.f
OBJ_DIR = obj_dir
PASS = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
